// ==== bench/tb_sbq_cfg.sv ====
`default_nettype none

`include "sbq_params.svh"

module tb_sbq_cfg;

    timeunit 1ns;
    timeprecision 100ps;

    import sbq_pkg::*;

    localparam int NQ = `SBQ_NUM_QUEUES;
    localparam logic [31:0] SEED = 32'h176f_bdc8;
    localparam int N_UNMAPPED = 5;
    localparam int N_RAND_WR = 32;
    localparam int N_MIXED = 24;
    localparam int N_READ_ALL = 1 + 6 * NQ;
    localparam int N_STATUS_ROUNDS = 4;
    localparam int TOTAL_TXN = 2 + N_UNMAPPED + N_RAND_WR + N_MIXED + 3 + 2 * N_READ_ALL
                               + N_STATUS_ROUNDS * NQ;
    localparam logic [31:0] UNMAPPED [N_UNMAPPED] = '{
        32'h0000_000c, 32'h0000_0040, 32'h0000_0118,
        `SBQ_QUEUE_BASE + NQ * `SBQ_REG_OFFSET, 32'hffff_fff0
    };

    logic                clk = 1'b0;
    logic                rst;
    axil_addr_t          aw;
    logic                aw_valid;
    logic                aw_ready;
    axil_w_t             w;
    logic                w_valid;
    logic                w_ready;
    axil_b_t             b;
    logic                b_valid;
    logic                b_ready;
    axil_addr_t          ar;
    logic                ar_valid;
    logic                ar_ready;
    axil_r_t             r;
    logic                r_valid;
    logic                r_ready;
    logic [NQ-1:0]       status_idle;
    queue_cfg_t [NQ-1:0] queue_cfg;
    logic [31:0]         clk_divide;

    logic [31:0] stim_lfsr;
    logic        throttle; // when set, b_ready and r_ready follow a random coin.
    int          issued_w;
    int          issued_r;
    int          b_seen;
    int          r_seen;
    logic [31:0] exp_r[$];
    logic [31:0] exp_addr[$];
    logic [31:0] clk_div_m;
    logic [31:0] qreg [NQ][4]; // base_lo, base_hi, capacity and enable of each queue.

    sbq_cfg_top dut (
        .clk(clk), .rst(rst),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .status_idle(status_idle), .queue_cfg(queue_cfg), .clk_divide(clk_divide)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] queue_addr(input int q, input int k);
        return `SBQ_QUEUE_BASE + q * `SBQ_REG_OFFSET + 4 * k;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // expected read data, taken from the model and the register map.
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] off;
        int          q;
        if (addr == `SBQ_ID_VERSION_REG) begin
            return `SBQ_ID_VERSION;
        end else if (addr == `SBQ_CAPABILITY_REG) begin
            return 32'd0;
        end else if (addr == `SBQ_CLK_DIVIDE_REG) begin
            return clk_div_m;
        end
        if (addr >= `SBQ_QUEUE_BASE && addr < `SBQ_QUEUE_BASE + NQ * `SBQ_REG_OFFSET) begin
            q = (addr - `SBQ_QUEUE_BASE) / `SBQ_REG_OFFSET;
            off = (addr - `SBQ_QUEUE_BASE) % `SBQ_REG_OFFSET;
            case (off)
                `SBQ_BASE_LO_REG: return qreg[q][0];
                `SBQ_BASE_HI_REG: return qreg[q][1];
                `SBQ_CAPACITY_REG: return qreg[q][2];
                `SBQ_ENABLE_REG: return qreg[q][3];
                `SBQ_RESET_REG: return 32'd0; // the bit has cleared itself by the B beat.
                `SBQ_STATUS_REG: return {31'd0, status_idle[q]};
                default: ;
            endcase
        end
        return `SBQ_UNMAPPED_VALUE;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else report_failure($sformatf("Mismatch %s: expected %h, actual %h",
                                      name, expected, actual));
    endtask

    task automatic check_outputs();
        check_value("clk_divide", clk_div_m, clk_divide);
        for (int q = 0; q < NQ; q++) begin
            check_value($sformatf("queue_cfg[%0d].base", q), {qreg[q][1], qreg[q][0]},
                        queue_cfg[q].base);
            check_value($sformatf("queue_cfg[%0d].capacity", q), qreg[q][2],
                        queue_cfg[q].capacity);
            check_value($sformatf("queue_cfg[%0d].enable", q), qreg[q][3],
                        queue_cfg[q].enable);
            check_value($sformatf("queue_cfg[%0d].reset", q), 0, queue_cfg[q].reset);
        end
    endtask

    task automatic model_defaults(input int q);
        qreg[q][0] = 32'd0;
        qreg[q][1] = 32'd0;
        qreg[q][2] = `SBQ_CAPACITY_DEFAULT;
        qreg[q][3] = 32'd0;
    endtask

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] off;
        int          q;
        if (addr == `SBQ_CLK_DIVIDE_REG) begin
            clk_div_m = merge_bytes(clk_div_m, data, strb);
        end else if (addr >= `SBQ_QUEUE_BASE
                     && addr < `SBQ_QUEUE_BASE + NQ * `SBQ_REG_OFFSET) begin
            q = (addr - `SBQ_QUEUE_BASE) / `SBQ_REG_OFFSET;
            off = (addr - `SBQ_QUEUE_BASE) % `SBQ_REG_OFFSET;
            case (off)
                `SBQ_BASE_LO_REG: qreg[q][0] = merge_bytes(qreg[q][0], data, strb);
                `SBQ_BASE_HI_REG: qreg[q][1] = merge_bytes(qreg[q][1], data, strb);
                `SBQ_CAPACITY_REG: qreg[q][2] = merge_bytes(qreg[q][2], data, strb);
                `SBQ_ENABLE_REG: if (strb[0]) qreg[q][3] = {31'd0, data[0]};
                `SBQ_RESET_REG: if (strb[0] && data[0]) model_defaults(q);
                default: ;
            endcase
        end
    endtask

    // AW and W are presented together, then the task waits for the B beat.
    task automatic axil_write(input logic [31:0] waddr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
        logic aw_taken;
        logic w_taken;
        @(negedge clk);
        aw.addr = waddr;
        w.data = wdata;
        w.strb = wstrb;
        aw_valid = 1'b1;
        w_valid = 1'b1;
        model_write(waddr, wdata, wstrb);
        issued_w++;
        while (aw_valid || w_valid) begin
            aw_taken = aw_valid && aw_ready;
            w_taken = w_valid && w_ready;
            @(negedge clk);
            if (aw_taken) aw_valid = 1'b0;
            if (w_taken) w_valid = 1'b0;
        end
        wait (b_seen == issued_w);
    endtask

    task automatic axil_read(input logic [31:0] raddr);
        logic ar_taken;
        @(negedge clk);
        ar.addr = raddr;
        ar_valid = 1'b1;
        exp_r.push_back(ref_read(raddr));
        exp_addr.push_back(raddr);
        issued_r++;
        while (ar_valid) begin
            ar_taken = ar_ready;
            @(negedge clk);
            if (ar_taken) ar_valid = 1'b0;
        end
        wait (r_seen == issued_r);
    endtask

    task automatic write_random();
        logic [31:0] p;
        logic [31:0] d;
        logic [31:0] s;
        p = rand_bits(4) % (1 + 4 * NQ);
        d = rand_bits(32);
        s = rand_bits(4);
        if (p == 0) axil_write(`SBQ_CLK_DIVIDE_REG, d, s[3:0]);
        else axil_write(queue_addr((p - 1) / 4, (p - 1) % 4), d, s[3:0]);
    endtask

    task automatic read_random();
        logic [31:0] p;
        p = rand_bits(4) % (1 + 6 * NQ);
        if (p == 0) axil_read(`SBQ_CLK_DIVIDE_REG);
        else axil_read(queue_addr((p - 1) / 6, (p - 1) % 6));
    endtask

    task automatic read_all();
        axil_read(`SBQ_CLK_DIVIDE_REG);
        for (int q = 0; q < NQ; q++) begin
            for (int k = 0; k < 6; k++) axil_read(queue_addr(q, k));
        end
    endtask

    // drives the response readys and checks every B and R beat mid-cycle.
    initial begin : response_checker
        logic [31:0] coin_lfsr;
        logic        b_hold;
        logic        r_hold;
        axil_b_t     b_prev;
        axil_r_t     r_prev;
        coin_lfsr = SEED;
        b_hold = 1'b0;
        r_hold = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        forever begin
            @(negedge clk);
            coin_lfsr = lfsr_next(coin_lfsr);
            b_ready = !throttle || coin_lfsr[0];
            coin_lfsr = lfsr_next(coin_lfsr);
            r_ready = !throttle || coin_lfsr[0];
            if (b_hold) begin
                assert (b_valid) else report_failure("B response withdrawn before it was taken");
                check_value("b", b_prev, b);
            end
            if (r_hold) begin
                assert (r_valid) else report_failure("R response withdrawn before it was taken");
                check_value("r", r_prev, r);
            end
            if (b_valid && b_ready) begin
                assert (b_seen < issued_w) else report_failure("B beat with no write pending");
                check_value("b.resp", 0, b.resp);
                b_seen++;
                check_outputs(); // registers have settled by the time B is visible.
            end
            if (r_valid && r_ready) begin
                assert (exp_r.size() > 0) else report_failure("R beat with no read pending");
                check_value($sformatf("r.data at %h", exp_addr.pop_front()),
                            exp_r.pop_front(), r.data);
                check_value("r.resp", 0, r.resp);
                r_seen++;
            end
            b_hold = b_valid && !b_ready;
            r_hold = r_valid && !r_ready;
            b_prev = b;
            r_prev = r;
        end
    end

    initial begin : watchdog
        #(TOTAL_TXN * 50 * 10);
        report_failure("timeout: the transactions did not finish in time");
    end

    initial begin : stimulus
        logic [31:0] pick;
        int          rq;
        stim_lfsr = SEED;
        throttle = 1'b0;
        rst = 1'b1;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        pick = rand_bits(NQ);
        status_idle = pick[NQ-1:0];
        clk_div_m = 32'd0;
        for (int q = 0; q < NQ; q++) model_defaults(q);
        repeat (2) @(negedge clk);
        rst = 1'b0;

        check_outputs();
        assert (!b_valid && !r_valid)
        else report_failure("a response is valid right after reset");

        axil_read(`SBQ_ID_VERSION_REG);
        axil_read(`SBQ_CAPABILITY_REG);
        for (int i = 0; i < N_UNMAPPED; i++) axil_read(UNMAPPED[i]);

        repeat (N_RAND_WR) write_random();
        read_all();

        throttle = 1'b1; // back-pressure stays on for the rest of the run.
        repeat (N_MIXED) begin
            pick = rand_bits(1);
            if (pick[0]) write_random();
            else read_random();
        end

        // make sure the chosen queue is away from its defaults, then reset it.
        pick = rand_bits(1);
        rq = pick % NQ;
        axil_write(queue_addr(rq, 2), 32'h0000_0100, 4'hf);
        axil_write(queue_addr(rq, 4), 32'h0000_0001, 4'h1);
        axil_read(queue_addr(rq, 4));
        read_all();

        repeat (N_STATUS_ROUNDS) begin
            pick = rand_bits(NQ);
            status_idle = pick[NQ-1:0];
            for (int q = 0; q < NQ; q++) axil_read(queue_addr(q, 5));
        end

        @(negedge clk);
        if (b_seen == issued_w && r_seen == issued_r && exp_r.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure($sformatf("response count is off: B %0d of %0d, R %0d of %0d",
                                     b_seen, issued_w, r_seen, issued_r));
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/sbq_pkg.sv
hw/axil_slice.sv
hw/axil_reg_bridge.sv
hw/sbq_config_regs.sv
hw/sbq_cfg_top.sv
bench/tb_sbq_cfg.sv

// ==== hw/axil_reg_bridge.sv ====
`default_nettype none

module axil_reg_bridge (
    input  wire                 clk,
    input  wire                 rst,
    input  wire sbq_pkg::axil_addr_t aw,
    input  wire                 aw_valid,
    output logic                aw_ready,
    input  wire sbq_pkg::axil_w_t    w,
    input  wire                 w_valid,
    output logic                w_ready,
    input  wire sbq_pkg::axil_addr_t ar,
    input  wire                 ar_valid,
    output logic                ar_ready,
    output sbq_pkg::axil_b_t    b,
    output logic                b_valid,
    input  wire                 b_ready,
    output sbq_pkg::axil_r_t    r,
    output logic                r_valid,
    input  wire                 r_ready,
    output sbq_pkg::reg_wr_t    wr,
    output logic                wr_en,
    output logic [31:0]         rd_addr,
    output logic                rd_en,
    input  wire  [31:0]         rd_data
);

    import sbq_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    bridge_state_e state;
    logic          do_write;
    logic          do_read;
    logic [31:0]   r_data_q;

    // writes take priority when both directions are pending.
    always_comb begin
        do_write = (state == IDLE) && aw_valid && w_valid;
        do_read = (state == IDLE) && !(aw_valid && w_valid) && ar_valid;
    end

    assign aw_ready = do_write; // AW and W are popped in the same cycle.
    assign w_ready = do_write;
    assign ar_ready = do_read;

    assign wr_en = do_write;
    assign wr = '{addr: aw.addr, data: w.data, strb: w.strb};
    assign rd_en = do_read;
    assign rd_addr = ar.addr;

    assign b_valid = (state == WRITE_RESP);
    assign b = '{resp: RESP_OKAY};
    assign r_valid = (state == READ_RESP);
    assign r = '{data: r_data_q, resp: RESP_OKAY};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (do_write) begin
                        state <= WRITE_RESP;
                    end else if (do_read) begin
                        state <= READ_RESP;
                    end
                end
                WRITE_RESP: if (b_ready) state <= IDLE;
                READ_RESP: if (r_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // the register file answers in the same cycle as rd_en.
    always_ff @(posedge clk) begin
        if (do_read) begin
            r_data_q <= rd_data;
        end
    end

    a_one_response: assert property (@(posedge clk) disable iff (rst)
        !(b_valid && r_valid));

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && rd_en));

endmodule

`default_nettype wire

// ==== hw/axil_slice.sv ====
`default_nettype none

module axil_slice #(
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire  [WIDTH-1:0] in_data,
    input  wire              in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  wire              out_ready
);

    logic [WIDTH-1:0] main_data;
    logic             main_valid;
    logic [WIDTH-1:0] skid_data;
    logic             skid_valid;
    logic             in_ready_q;
    logic             in_fire;
    logic             out_fire;
    logic             main_load;

    assign in_ready = in_ready_q;
    assign out_data = main_data;
    assign out_valid = main_valid;

    always_comb begin
        in_fire = in_valid && in_ready_q;
        out_fire = main_valid && out_ready;
        main_load = out_fire || !main_valid; // main is free to take a new beat.
    end

    // control flags. ready only depends on the skid entry, never on out_ready.
    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready_q <= 1'b0;
        end else begin
            if (main_load) begin
                main_valid <= skid_valid || in_fire;
                skid_valid <= 1'b0;
                in_ready_q <= 1'b1;
            end else if (in_fire) begin
                skid_valid <= 1'b1; // main is stalled, park the beat.
                in_ready_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_load && in_fire) begin
            skid_data <= in_data;
        end
    end

    // a stalled beat must be held unchanged until it is taken.
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== hw/sbq_cfg_top.sv ====
`default_nettype none

`include "sbq_params.svh"

module sbq_cfg_top (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire sbq_pkg::axil_addr_t                   aw,
    input  wire                                        aw_valid,
    output logic                                       aw_ready,
    input  wire sbq_pkg::axil_w_t                      w,
    input  wire                                        w_valid,
    output logic                                       w_ready,
    output sbq_pkg::axil_b_t                           b,
    output logic                                       b_valid,
    input  wire                                        b_ready,
    input  wire sbq_pkg::axil_addr_t                   ar,
    input  wire                                        ar_valid,
    output logic                                       ar_ready,
    output sbq_pkg::axil_r_t                           r,
    output logic                                       r_valid,
    input  wire                                        r_ready,
    input  wire  [`SBQ_NUM_QUEUES-1:0]                 status_idle,
    output sbq_pkg::queue_cfg_t [`SBQ_NUM_QUEUES-1:0]  queue_cfg,
    output logic [31:0]                                clk_divide
);

    import sbq_pkg::*;

    axil_addr_t aw_q, ar_q;
    axil_w_t    w_q;
    axil_b_t    b_q;
    axil_r_t    r_q;
    logic       aw_q_valid, aw_q_ready, w_q_valid, w_q_ready, ar_q_valid, ar_q_ready;
    logic       b_q_valid, b_q_ready, r_q_valid, r_q_ready;
    reg_wr_t    wr;
    logic       wr_en, rd_en;
    logic [31:0] rd_addr, rd_data;

    // request channels toward the bridge.
    axil_slice #(.WIDTH($bits(axil_addr_t))) u_aw_slice (
        .clk(clk), .rst(rst),
        .in_data(aw), .in_valid(aw_valid), .in_ready(aw_ready),
        .out_data(aw_q), .out_valid(aw_q_valid), .out_ready(aw_q_ready)
    );

    axil_slice #(.WIDTH($bits(axil_w_t))) u_w_slice (
        .clk(clk), .rst(rst),
        .in_data(w), .in_valid(w_valid), .in_ready(w_ready),
        .out_data(w_q), .out_valid(w_q_valid), .out_ready(w_q_ready)
    );

    axil_slice #(.WIDTH($bits(axil_addr_t))) u_ar_slice (
        .clk(clk), .rst(rst),
        .in_data(ar), .in_valid(ar_valid), .in_ready(ar_ready),
        .out_data(ar_q), .out_valid(ar_q_valid), .out_ready(ar_q_ready)
    );

    // response channels back to the host.
    axil_slice #(.WIDTH($bits(axil_b_t))) u_b_slice (
        .clk(clk), .rst(rst),
        .in_data(b_q), .in_valid(b_q_valid), .in_ready(b_q_ready),
        .out_data(b), .out_valid(b_valid), .out_ready(b_ready)
    );

    axil_slice #(.WIDTH($bits(axil_r_t))) u_r_slice (
        .clk(clk), .rst(rst),
        .in_data(r_q), .in_valid(r_q_valid), .in_ready(r_q_ready),
        .out_data(r), .out_valid(r_valid), .out_ready(r_ready)
    );

    axil_reg_bridge u_bridge (
        .clk(clk), .rst(rst),
        .aw(aw_q), .aw_valid(aw_q_valid), .aw_ready(aw_q_ready),
        .w(w_q), .w_valid(w_q_valid), .w_ready(w_q_ready),
        .ar(ar_q), .ar_valid(ar_q_valid), .ar_ready(ar_q_ready),
        .b(b_q), .b_valid(b_q_valid), .b_ready(b_q_ready),
        .r(r_q), .r_valid(r_q_valid), .r_ready(r_q_ready),
        .wr(wr), .wr_en(wr_en),
        .rd_addr(rd_addr), .rd_en(rd_en), .rd_data(rd_data)
    );

    sbq_config_regs u_regs (
        .clk(clk), .rst(rst),
        .wr(wr), .wr_en(wr_en),
        .rd_addr(rd_addr), .rd_en(rd_en), .rd_data(rd_data),
        .status_idle(status_idle),
        .queue_cfg(queue_cfg),
        .clk_divide(clk_divide)
    );

endmodule

`default_nettype wire

// ==== hw/sbq_config_regs.sv ====
`default_nettype none

`include "sbq_params.svh"

module sbq_config_regs (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire sbq_pkg::reg_wr_t                      wr,
    input  wire                                        wr_en,
    input  wire  [31:0]                                rd_addr,
    input  wire                                        rd_en,
    output logic [31:0]                                rd_data,
    input  wire  [`SBQ_NUM_QUEUES-1:0]                 status_idle,
    output sbq_pkg::queue_cfg_t [`SBQ_NUM_QUEUES-1:0]  queue_cfg,
    output logic [31:0]                                clk_divide
);

    import sbq_pkg::*;

    localparam queue_cfg_t QUEUE_DEFAULT = '{
        base: 64'd0,
        capacity: `SBQ_CAPACITY_DEFAULT,
        enable: 1'b0,
        reset: 1'b0
    };

    function automatic logic [31:0] queue_reg(input int q, input logic [31:0] off);
        return `SBQ_QUEUE_BASE + q * `SBQ_REG_OFFSET + off;
    endfunction

    // merge new data into a word, one byte lane per strobe bit.
    function automatic logic [31:0] apply_strb(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_divide <= 32'd0;
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                queue_cfg[q] <= QUEUE_DEFAULT;
            end
        end else begin
            if (wr_en && wr.addr == `SBQ_CLK_DIVIDE_REG) begin
                clk_divide <= apply_strb(clk_divide, wr.data, wr.strb);
            end
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                if (queue_cfg[q].reset) begin
                    queue_cfg[q] <= QUEUE_DEFAULT; // also clears the reset bit.
                end else if (wr_en) begin
                    if (wr.addr == queue_reg(q, `SBQ_BASE_LO_REG)) begin
                        queue_cfg[q].base[31:0] <=
                            apply_strb(queue_cfg[q].base[31:0], wr.data, wr.strb);
                    end else if (wr.addr == queue_reg(q, `SBQ_BASE_HI_REG)) begin
                        queue_cfg[q].base[63:32] <=
                            apply_strb(queue_cfg[q].base[63:32], wr.data, wr.strb);
                    end else if (wr.addr == queue_reg(q, `SBQ_CAPACITY_REG)) begin
                        queue_cfg[q].capacity <=
                            apply_strb(queue_cfg[q].capacity, wr.data, wr.strb);
                    end else if (wr.addr == queue_reg(q, `SBQ_ENABLE_REG) && wr.strb[0]) begin
                        queue_cfg[q].enable <= wr.data[0];
                    end else if (wr.addr == queue_reg(q, `SBQ_RESET_REG) && wr.strb[0]) begin
                        queue_cfg[q].reset <= wr.data[0];
                    end
                end
            end
        end
    end

    // anything not matched below reads back as all ones.
    always_comb begin
        rd_data = `SBQ_UNMAPPED_VALUE;
        if (rd_en) begin
            if (rd_addr == `SBQ_ID_VERSION_REG) begin
                rd_data = `SBQ_ID_VERSION;
            end else if (rd_addr == `SBQ_CAPABILITY_REG) begin
                rd_data = 32'd0;
            end else if (rd_addr == `SBQ_CLK_DIVIDE_REG) begin
                rd_data = clk_divide;
            end
            for (int q = 0; q < `SBQ_NUM_QUEUES; q++) begin
                if (rd_addr == queue_reg(q, `SBQ_BASE_LO_REG)) begin
                    rd_data = queue_cfg[q].base[31:0];
                end else if (rd_addr == queue_reg(q, `SBQ_BASE_HI_REG)) begin
                    rd_data = queue_cfg[q].base[63:32];
                end else if (rd_addr == queue_reg(q, `SBQ_CAPACITY_REG)) begin
                    rd_data = queue_cfg[q].capacity;
                end else if (rd_addr == queue_reg(q, `SBQ_ENABLE_REG)) begin
                    rd_data = {31'd0, queue_cfg[q].enable};
                end else if (rd_addr == queue_reg(q, `SBQ_RESET_REG)) begin
                    rd_data = {31'd0, queue_cfg[q].reset};
                end else if (rd_addr == queue_reg(q, `SBQ_STATUS_REG)) begin
                    rd_data = {31'd0, status_idle[q]};
                end
            end
        end
    end

    for (genvar g = 0; g < `SBQ_NUM_QUEUES; g++) begin : g_reset_check
        a_reset_pulse: assert property (@(posedge clk) disable iff (rst)
            queue_cfg[g].reset |=> !queue_cfg[g].reset);
    end

endmodule

`default_nettype wire

// ==== hw/sbq_params.svh ====
`ifndef SBQ_PARAMS_SVH
`define SBQ_PARAMS_SVH

// number of queue blocks in the register map.
`define SBQ_NUM_QUEUES 2

`define SBQ_ID_VERSION_REG 32'h0000_0000
`define SBQ_CAPABILITY_REG 32'h0000_0004
`define SBQ_CLK_DIVIDE_REG 32'h0000_0008

`define SBQ_QUEUE_BASE 32'h0000_0100
`define SBQ_REG_OFFSET 32'h0000_0040 // stride between queue blocks.

`define SBQ_BASE_LO_REG 32'h0000_0000
`define SBQ_BASE_HI_REG 32'h0000_0004
`define SBQ_CAPACITY_REG 32'h0000_0008
`define SBQ_ENABLE_REG 32'h0000_000c
`define SBQ_RESET_REG 32'h0000_0010
`define SBQ_STATUS_REG 32'h0000_0014

`define SBQ_ID_VERSION 32'h1234_0000
`define SBQ_UNMAPPED_VALUE 32'hffff_ffff
`define SBQ_CAPACITY_DEFAULT 32'd2

`endif

// ==== hw/sbq_pkg.sv ====
`default_nettype none

package sbq_pkg;

    typedef struct packed {
        logic [31:0] addr;
    } axil_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    // one register write as issued by the bridge.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_wr_t;

    typedef struct packed {
        logic [63:0] base;
        logic [31:0] capacity;
        logic        enable;
        logic        reset; // self-clearing, restores the queue defaults.
    } queue_cfg_t;

    typedef enum logic [1:0] {IDLE, WRITE_RESP, READ_RESP} bridge_state_e;

endpackage

`default_nettype wire
